/* rtl/ci_bus_pkg.sv */
`default_nettype none

// Core bus types shared by the harness blocks
package ci_bus_pkg;

  // Byte address as seen on a core bus
  typedef logic [31:0] bus_addr_t;

  // One bus data word
  typedef logic [31:0] bus_data_t;

  // Host port selector, up to 16 memory ports
  typedef logic [3:0] port_sel_t;

  // Word index, byte address without bits 1:0
  typedef logic [29:0] word_idx_t;

endpackage : ci_bus_pkg

`default_nettype wire

/* rtl/ci_ctrl_pkg.sv */
`default_nettype none

// Run control definitions for the CI harness
package ci_ctrl_pkg;

  // Loader phases
  typedef enum logic [1:0] {
    LOAD, // Core held in reset, host writes accepted
    HOLD, // Counting down to core release
    RUN   // Core running
  } loader_state_t;

  // A core write to this address ends the test
  localparam ci_bus_pkg::bus_addr_t TOHOST_ADDR = 32'h8000_0000;

  // Cycles between start and core release
  localparam int DEFAULT_RESET_CYCLES = 8;

endpackage : ci_ctrl_pkg

`default_nettype wire

/* rtl/ci_program_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module ci_program_loader #(
  parameter int N_PORTS          = 2,
  parameter int RESET_CLK_CYCLES = ci_ctrl_pkg::DEFAULT_RESET_CYCLES
) (
  input  wire logic                   sys_clk_i,
  input  wire logic                   arst_n_i,
  input  wire logic                   host_load_i,  // One cycle write strobe
  input  wire ci_bus_pkg::port_sel_t  host_port_i,
  input  wire ci_bus_pkg::bus_addr_t  host_addr_i,
  input  wire ci_bus_pkg::bus_data_t  host_data_i,
  input  wire logic                   host_start_i, // Release request
  output logic [N_PORTS-1:0]          load_we_o,
  output ci_bus_pkg::bus_addr_t       load_addr_o,
  output ci_bus_pkg::bus_data_t       load_data_o,
  output logic                        core_rst_o
);

  localparam int CNT_W = $clog2(RESET_CLK_CYCLES + 1);

  ci_ctrl_pkg::loader_state_t state_q;
  logic [CNT_W-1:0]           hold_cnt_q;

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ci_ctrl_pkg::LOAD;
      hold_cnt_q <= '0;
    end else begin
      case (state_q)
        ci_ctrl_pkg::LOAD: begin
          if (host_start_i) begin
            state_q    <= ci_ctrl_pkg::HOLD;
            hold_cnt_q <= CNT_W'(RESET_CLK_CYCLES - 1); // Release lands on the Nth edge
          end
        end
        ci_ctrl_pkg::HOLD: begin
          if (hold_cnt_q == '0) begin
            state_q <= ci_ctrl_pkg::RUN;
          end else begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
          end
        end
        default: state_q <= ci_ctrl_pkg::RUN; // Stays here until reset
      endcase
    end
  end

  // Core stays in reset until the countdown is over
  assign core_rst_o = (state_q != ci_ctrl_pkg::RUN);

  // One-hot strobe for the selected port, out of range ports dropped
  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      load_we_o[p] = host_load_i && (state_q == ci_ctrl_pkg::LOAD) &&
                     (host_port_i == ci_bus_pkg::port_sel_t'(p));
    end
  end

  assign load_addr_o = host_addr_i;
  assign load_data_o = host_data_i;

  a_load_onehot: assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    $onehot0(load_we_o)
  ) else $error("more than one load strobe active");

endmodule : ci_program_loader

`default_nettype wire

/* rtl/ci_bus_responder.sv */
`timescale 1ns/1ps
`default_nettype none

module ci_bus_responder #(
  parameter int MEM_WORDS = 256
) (
  input  wire logic                  sys_clk_i,
  input  wire logic                  arst_n_i,
  input  wire logic                  cyc_i,
  input  wire logic                  stb_i,
  input  wire logic                  we_i,      // 1 = write
  input  wire ci_bus_pkg::bus_addr_t addr_i,
  input  wire ci_bus_pkg::bus_data_t data_i,
  output ci_bus_pkg::bus_data_t      data_o,
  output logic                       ack_o,
  input  wire logic                  load_we_i,
  input  wire ci_bus_pkg::bus_addr_t load_addr_i,
  input  wire ci_bus_pkg::bus_data_t load_data_i,
  output logic                       wr_evt_o,  // Accepted core write
  output ci_bus_pkg::bus_addr_t      wr_addr_o,
  output ci_bus_pkg::bus_data_t      wr_data_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  ci_bus_pkg::bus_data_t mem [MEM_WORDS];

  ci_bus_pkg::word_idx_t core_word;
  ci_bus_pkg::word_idx_t load_word;
  logic                  core_in_range;
  logic                  load_in_range;
  logic                  req;

  logic                  ack_q;
  logic                  wr_evt_q;
  ci_bus_pkg::bus_data_t rd_data_q;
  ci_bus_pkg::bus_addr_t wr_addr_q;
  ci_bus_pkg::bus_data_t wr_data_q;

  assign core_word     = addr_i[31:2];
  assign load_word     = load_addr_i[31:2];
  assign core_in_range = (core_word < ci_bus_pkg::word_idx_t'(MEM_WORDS));
  assign load_in_range = (load_word < ci_bus_pkg::word_idx_t'(MEM_WORDS));

  // New request only while no ack is out, so a held request gets every other cycle
  assign req = cyc_i && stb_i && !ack_q;

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q    <= 1'b0;
      wr_evt_q <= 1'b0;
    end else begin
      ack_q    <= req;
      wr_evt_q <= req && we_i;
    end
  end

  // Memory and payload path
  always_ff @(posedge sys_clk_i) begin
    if (req && we_i && core_in_range) begin
      mem[core_word[IDX_W-1:0]] <= data_i;
    end else if (load_we_i && load_in_range) begin
      mem[load_word[IDX_W-1:0]] <= load_data_i;
    end
    if (req && !we_i) begin
      rd_data_q <= core_in_range ? mem[core_word[IDX_W-1:0]] : '0; // Unmapped reads zero
    end
    if (req && we_i) begin
      wr_addr_q <= addr_i;
      wr_data_q <= data_i;
    end
  end

  assign ack_o     = ack_q;
  assign data_o    = rd_data_q;
  assign wr_evt_o  = wr_evt_q;
  assign wr_addr_o = wr_addr_q;
  assign wr_data_o = wr_data_q;

  a_ack_single: assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    ack_o |=> !ack_o
  ) else $error("ack held for two cycles");

  // Loader only writes while the core is held in reset
  a_load_no_core: assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    load_we_i |-> !(cyc_i && stb_i)
  ) else $error("load write during a core request");

endmodule : ci_bus_responder

`default_nettype wire

/* rtl/ci_completion_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module ci_completion_monitor #(
  parameter int N_PORTS = 2
) (
  input  wire logic                                sys_clk_i,
  input  wire logic                                arst_n_i,
  input  wire logic [N_PORTS-1:0]                  wr_evt_i,
  input  wire ci_bus_pkg::bus_addr_t [N_PORTS-1:0] wr_addr_i,
  input  wire ci_bus_pkg::bus_data_t [N_PORTS-1:0] wr_data_i,
  output logic                                     done_o,
  output ci_bus_pkg::bus_data_t                    result_o
);

  logic                  hit_any;
  ci_bus_pkg::bus_data_t hit_data;
  logic                  done_q;
  ci_bus_pkg::bus_data_t result_q;

  // Scan from the top so the lowest port is the last to assign
  always_comb begin
    hit_any  = 1'b0;
    hit_data = '0;
    for (int p = N_PORTS - 1; p >= 0; p--) begin
      if (wr_evt_i[p] && (wr_addr_i[p] == ci_ctrl_pkg::TOHOST_ADDR)) begin
        hit_any  = 1'b1;
        hit_data = wr_data_i[p];
      end
    end
  end

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b0;
    end else if (hit_any) begin
      done_q <= 1'b1; // Sticky until reset
    end
  end

  // First tohost write only
  always_ff @(posedge sys_clk_i) begin
    if (hit_any && !done_q) begin
      result_q <= hit_data;
    end
  end

  assign done_o   = done_q;
  assign result_o = result_q;

  a_result_frozen: assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    done_o |=> $stable(result_o)
  ) else $error("result changed after done");

endmodule : ci_completion_monitor

`default_nettype wire

/* rtl/ci_harness_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ci_harness_top #(
  parameter int N_PORTS          = 2,   // Port 0 instructions, port 1 data
  parameter int MEM_WORDS        = 256,
  parameter int RESET_CLK_CYCLES = ci_ctrl_pkg::DEFAULT_RESET_CYCLES
) (
  input  wire logic                                sys_clk_i,
  input  wire logic                                arst_n_i,

  // Host load port
  input  wire logic                                host_load_i,
  input  wire ci_bus_pkg::port_sel_t               host_port_i,
  input  wire ci_bus_pkg::bus_addr_t               host_addr_i,
  input  wire ci_bus_pkg::bus_data_t               host_data_i,
  input  wire logic                                host_start_i,

  // Run control and result
  output logic                                     core_rst_o,
  output logic                                     done_o,
  output ci_bus_pkg::bus_data_t                    result_o,

  // Core buses, one entry per port
  input  wire logic [N_PORTS-1:0]                  core_cyc_i,
  input  wire logic [N_PORTS-1:0]                  core_stb_i,
  input  wire logic [N_PORTS-1:0]                  core_we_i,
  input  wire ci_bus_pkg::bus_addr_t [N_PORTS-1:0] core_addr_i,
  input  wire ci_bus_pkg::bus_data_t [N_PORTS-1:0] core_data_i,
  output ci_bus_pkg::bus_data_t [N_PORTS-1:0]      core_data_o,
  output logic [N_PORTS-1:0]                       core_ack_o
);

  logic [N_PORTS-1:0]                  load_we;
  ci_bus_pkg::bus_addr_t               load_addr;
  ci_bus_pkg::bus_data_t               load_data;
  logic [N_PORTS-1:0]                  wr_evt;
  ci_bus_pkg::bus_addr_t [N_PORTS-1:0] wr_addr;
  ci_bus_pkg::bus_data_t [N_PORTS-1:0] wr_data;

  ci_program_loader #(
    .N_PORTS          (N_PORTS),
    .RESET_CLK_CYCLES (RESET_CLK_CYCLES)
  ) u_loader (
    .sys_clk_i    (sys_clk_i),
    .arst_n_i     (arst_n_i),
    .host_load_i  (host_load_i),
    .host_port_i  (host_port_i),
    .host_addr_i  (host_addr_i),
    .host_data_i  (host_data_i),
    .host_start_i (host_start_i),
    .load_we_o    (load_we),
    .load_addr_o  (load_addr),
    .load_data_o  (load_data),
    .core_rst_o   (core_rst_o)
  );

  // One memory responder per core bus
  for (genvar p = 0; p < N_PORTS; p++) begin : g_port
    ci_bus_responder #(
      .MEM_WORDS (MEM_WORDS)
    ) u_responder (
      .sys_clk_i   (sys_clk_i),
      .arst_n_i    (arst_n_i),
      .cyc_i       (core_cyc_i[p]),
      .stb_i       (core_stb_i[p]),
      .we_i        (core_we_i[p]),
      .addr_i      (core_addr_i[p]),
      .data_i      (core_data_i[p]),
      .data_o      (core_data_o[p]),
      .ack_o       (core_ack_o[p]),
      .load_we_i   (load_we[p]),
      .load_addr_i (load_addr), // Shared by all ports
      .load_data_i (load_data),
      .wr_evt_o    (wr_evt[p]),
      .wr_addr_o   (wr_addr[p]),
      .wr_data_o   (wr_data[p])
    );
  end

  ci_completion_monitor #(
    .N_PORTS (N_PORTS)
  ) u_monitor (
    .sys_clk_i (sys_clk_i),
    .arst_n_i  (arst_n_i),
    .wr_evt_i  (wr_evt),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .done_o    (done_o),
    .result_o  (result_o)
  );

endmodule : ci_harness_top

`default_nettype wire

/* tests/ci_harness_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ci_harness_tb;

  localparam int N_PORTS        = 2;
  localparam int MEM_WORDS      = 256;
  localparam int RESET_CYCLES   = ci_ctrl_pkg::DEFAULT_RESET_CYCLES;
  localparam int N_LOADS        = 8;    // Random words per port
  localparam int TIMEOUT_CYCLES = 2000; // Full run needs a few hundred

  logic                                sys_clk;
  logic                                arst_n;
  logic                                host_load;
  ci_bus_pkg::port_sel_t               host_port;
  ci_bus_pkg::bus_addr_t               host_addr;
  ci_bus_pkg::bus_data_t               host_data;
  logic                                host_start;
  logic                                core_rst;
  logic                                done;
  ci_bus_pkg::bus_data_t               result;
  logic [N_PORTS-1:0]                  core_cyc;
  logic [N_PORTS-1:0]                  core_stb;
  logic [N_PORTS-1:0]                  core_we;
  ci_bus_pkg::bus_addr_t [N_PORTS-1:0] core_addr;
  ci_bus_pkg::bus_data_t [N_PORTS-1:0] core_wdata;
  ci_bus_pkg::bus_data_t [N_PORTS-1:0] core_rdata;
  logic [N_PORTS-1:0]                  core_ack;

  ci_bus_pkg::bus_data_t shadow [N_PORTS][MEM_WORDS];
  int unsigned           err_cnt;
  int unsigned           cycle_cnt;
  logic                  start_seen;
  int unsigned           rel_cnt;
  logic                  exp_core_rst;
  logic                  tohost_issued;
  ci_bus_pkg::bus_data_t exp_result;

  ci_harness_top ci_harness_top_inst (
    .sys_clk_i    (sys_clk),
    .arst_n_i     (arst_n),
    .host_load_i  (host_load),
    .host_port_i  (host_port),
    .host_addr_i  (host_addr),
    .host_data_i  (host_data),
    .host_start_i (host_start),
    .core_rst_o   (core_rst),
    .done_o       (done),
    .result_o     (result),
    .core_cyc_i   (core_cyc),
    .core_stb_i   (core_stb),
    .core_we_i    (core_we),
    .core_addr_i  (core_addr),
    .core_data_i  (core_wdata),
    .core_data_o  (core_rdata),
    .core_ack_o   (core_ack)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  // Expected release where only the first start counts
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      start_seen <= 1'b0;
      rel_cnt    <= 0;
    end else if (host_start && !start_seen) begin
      start_seen <= 1'b1;
      rel_cnt    <= RESET_CYCLES;
    end else if (rel_cnt != 0) begin
      rel_cnt <= rel_cnt - 1;
    end
  end

  assign exp_core_rst = !start_seen || (rel_cnt != 0);

  a_core_rst: assert property (@(posedge sys_clk) core_rst == exp_core_rst)
    else begin
      err_cnt++;
      $display("MISMATCH t=%0t core_rst_o exp=%0b got=%0b",
               $time, $sampled(exp_core_rst), $sampled(core_rst));
    end

  a_idle_in_reset: assert property (@(posedge sys_clk) core_rst |-> (core_ack == '0) && !done)
    else begin
      err_cnt++;
      $display("MISMATCH t=%0t core_ack_o/done_o exp=%b/0 got=%b/%0b",
               $time, {N_PORTS{1'b0}}, $sampled(core_ack), $sampled(done));
    end

  a_done_early: assert property (@(posedge sys_clk) !tohost_issued |-> !done)
    else begin
      err_cnt++;
      $display("MISMATCH t=%0t done_o exp=0 got=%0b", $time, $sampled(done));
    end

  a_done_sticky: assert property (@(posedge sys_clk) disable iff (!arst_n) done |=> done)
    else begin
      err_cnt++;
      $display("MISMATCH t=%0t done_o exp=1 got=%0b", $time, $sampled(done));
    end

  a_result: assert property (@(posedge sys_clk) disable iff (!arst_n) done |-> result == exp_result)
    else begin
      err_cnt++;
      $display("MISMATCH t=%0t result_o exp=%h got=%h", $time, $sampled(exp_result),
               $sampled(result));
    end

  for (genvar p = 0; p < N_PORTS; p++) begin : g_ack_chk
    // Ack one cycle after the request and high for one cycle
    a_ack_timing: assert property (@(posedge sys_clk) disable iff (!arst_n)
      $rose(core_cyc[p] && core_stb[p]) |=> core_ack[p] ##1 !core_ack[p])
      else begin
        err_cnt++;
        $display("port %0d ack late or longer than one cycle at %0t", p, $time);
      end
  end

  task automatic tick();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic host_write(input int port, input ci_bus_pkg::bus_addr_t addr,
                            input ci_bus_pkg::bus_data_t data);
    host_load = 1'b1;
    host_port = ci_bus_pkg::port_sel_t'(port);
    host_addr = addr;
    host_data = data;
    tick();
    host_load = 1'b0;
  endtask

  task automatic core_access(input int port, input logic we, input ci_bus_pkg::bus_addr_t addr,
                             input ci_bus_pkg::bus_data_t wdata,
                             output ci_bus_pkg::bus_data_t rdata);
    int unsigned wait_cnt;
    core_cyc[port]   = 1'b1;
    core_stb[port]   = 1'b1;
    core_we[port]    = we;
    core_addr[port]  = addr;
    core_wdata[port] = wdata;
    wait_cnt = 0;
    do begin
      tick();
      wait_cnt++;
    end while (!core_ack[port] && wait_cnt < 16);
    if (!core_ack[port]) begin
      err_cnt++;
      $display("no ack from port %0d for address %h at %0t", port, addr, $time);
    end
    rdata = core_rdata[port]; // Valid in the ack cycle
    core_cyc[port] = 1'b0;
    core_stb[port] = 1'b0;
    core_we[port]  = 1'b0;
    tick();
  endtask

  task automatic core_write(input int port, input ci_bus_pkg::bus_addr_t addr,
                            input ci_bus_pkg::bus_data_t data);
    ci_bus_pkg::bus_data_t unused_rd;
    core_access(port, 1'b1, addr, data, unused_rd);
    if ((addr >> 2) < MEM_WORDS) begin
      shadow[port][int'(addr >> 2)] = data;
    end
  endtask

  task automatic read_check(input int port, input ci_bus_pkg::bus_addr_t addr,
                            input ci_bus_pkg::bus_data_t exp);
    ci_bus_pkg::bus_data_t got;
    core_access(port, 1'b0, addr, '0, got);
    a_read_data: assert (got == exp) else begin
      err_cnt++;
      $display("MISMATCH t=%0t core_data_o[%0d] addr=%h exp=%h got=%h",
               $time, port, addr, exp, got);
    end
  endtask

  initial begin
    int unsigned           idx [N_PORTS][N_LOADS];
    ci_bus_pkg::bus_addr_t addr;
    ci_bus_pkg::bus_data_t data;
    ci_bus_pkg::bus_data_t unused_rd;
    void'($urandom(32'haf388fd0));
    err_cnt       = 0;
    tohost_issued = 1'b0;
    exp_result    = '0;
    arst_n        = 1'b1;
    host_load     = 1'b0;
    host_port     = '0;
    host_addr     = '0;
    host_data     = '0;
    host_start    = 1'b0;
    core_cyc      = '0;
    core_stb      = '0;
    core_we       = '0;
    core_addr     = '0;
    core_wdata    = '0;
    #1 arst_n = 1'b0;
    repeat (10) @(posedge sys_clk);
    #1 arst_n = 1'b1;

    for (int p = 0; p < N_PORTS; p++) begin
      for (int i = 0; i < N_LOADS; i++) begin
        idx[p][i] = $urandom_range(MEM_WORDS - 1);
        data      = $urandom;
        host_write(p, ci_bus_pkg::bus_addr_t'(idx[p][i] * 4), data);
        shadow[p][idx[p][i]] = data;
      end
    end

    // Start and a second start inside the hold phase
    host_start = 1'b1;
    tick();
    host_start = 1'b0;
    repeat (3) tick();
    host_start = 1'b1;
    tick();
    host_start = 1'b0;
    while (core_rst) tick();
    host_start = 1'b1; // Ignored once running
    tick();
    host_start = 1'b0;

    for (int p = 0; p < N_PORTS; p++) begin
      for (int i = 0; i < N_LOADS; i++) begin
        addr = ci_bus_pkg::bus_addr_t'(idx[p][i] * 4);
        read_check(p, addr, shadow[p][idx[p][i]]);
      end
    end

    // Same word on both ports
    addr = ci_bus_pkg::bus_addr_t'($urandom_range(MEM_WORDS - 1) * 4);
    core_write(0, addr, $urandom);
    core_write(1, addr, $urandom);
    read_check(0, addr, shadow[0][int'(addr >> 2)]);
    read_check(1, addr, shadow[1][int'(addr >> 2)]);

    // Late host load must be dropped
    addr = ci_bus_pkg::bus_addr_t'(idx[0][0] * 4);
    host_write(0, addr, ~shadow[0][idx[0][0]]);
    read_check(0, addr, shadow[0][idx[0][0]]);

    // Out of range write aliasing a loaded word
    addr = ci_bus_pkg::bus_addr_t'((MEM_WORDS + idx[1][1]) * 4);
    core_write(1, addr, $urandom);
    read_check(1, addr, '0);
    read_check(1, ci_bus_pkg::bus_addr_t'(idx[1][1] * 4), shadow[1][idx[1][1]]);

    data          = $urandom;
    exp_result    = data;
    tohost_issued = 1'b1;
    core_access(1, 1'b1, ci_ctrl_pkg::TOHOST_ADDR, data, unused_rd);
    a_done_set: assert (done && result == data) else begin
      err_cnt++;
      $display("MISMATCH t=%0t done_o/result_o exp=1/%h got=%0b/%h", $time, data, done, result);
    end
    core_access(1, 1'b1, ci_ctrl_pkg::TOHOST_ADDR, ~data, unused_rd); // Must not overwrite
    repeat (3) tick();

    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge sys_clk);
      cycle_cnt++;
    end
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule : ci_harness_tb

`default_nettype wire

/* project.f */
rtl/ci_bus_pkg.sv
rtl/ci_ctrl_pkg.sv
rtl/ci_program_loader.sv
rtl/ci_bus_responder.sv
rtl/ci_completion_monitor.sv
rtl/ci_harness_top.sv
tests/ci_harness_tb.sv

/* Bender.yml */
package:
  name: ci_harness

sources:
  # Packages first, then the RTL blocks and the top level
  - rtl/ci_bus_pkg.sv
  - rtl/ci_ctrl_pkg.sv
  - rtl/ci_program_loader.sv
  - rtl/ci_bus_responder.sv
  - rtl/ci_completion_monitor.sv
  - rtl/ci_harness_top.sv
  - target: test
    files:
      - tests/ci_harness_tb.sv
